// File: hw/rv_pkg.sv
package rv_pkg;

    // instruction views, one per encoding format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_s;

    // also carries the scattered jal immediate
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
        s_fmt_s s;
        b_fmt_s b;
        u_fmt_s u;
    } rv_instr_u;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSB
    } alu_op_e;

    // encodings follow funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_type_e;

    typedef enum logic [1:0] {WD_ALU, WD_MEM, WD_PC4} wd_sel_e;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        mem_read;
        logic        alu_src_imm;
        alu_op_e     alu_op;
        mem_type_e   mem_type;
        wd_sel_e     wd_sel;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic [31:0] imm;
    } ctrl_s;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] wdata;
    } retire_s;

    typedef enum logic [1:0] {CFG_CTRL, CFG_BREAK, CFG_RETIRED, CFG_PC} cfg_addr_e;

endpackage

// File: hw/rv_decode.sv
module rv_decode import rv_pkg::*; (
    input  rv_instr_u instr_i,
    output ctrl_s     ctrl_o
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // shared by R and I types, funct7 bit 5 picks sub and sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        case (f3)
            3'b000:  arith_op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            3'b111:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD;
        endcase
    endfunction

    assign imm_i = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
    assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
    assign imm_u = {instr_i.u.imm20, 12'h000};
    // j immediate bits sit in the upper 20 bits in scrambled order
    assign imm_j = {{11{instr_i.u.imm20[19]}}, instr_i.u.imm20[19], instr_i.u.imm20[7:0],
                    instr_i.u.imm20[8], instr_i.u.imm20[18:9], 1'b0};

    always_comb begin
        ctrl_o = '0;
        case (instr_i.r.opcode)
            OP_R: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = arith_op(instr_i.r.funct3, instr_i.r.funct7[5], 1'b1);
            end
            OP_I: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = arith_op(instr_i.i.funct3, instr_i.r.funct7[5], 1'b0);
                ctrl_o.imm         = imm_i;
            end
            OP_LOAD: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_type    = mem_type_e'(instr_i.i.funct3);
                ctrl_o.wd_sel      = WD_MEM;
                ctrl_o.imm         = imm_i;
            end
            OP_STORE: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_type    = mem_type_e'(instr_i.s.funct3);
                ctrl_o.imm         = imm_s;
            end
            OP_BRANCH: begin
                // compare through sub, fetch reads the flags
                ctrl_o.is_branch = 1'b1;
                ctrl_o.alu_op    = ALU_SUB;
                ctrl_o.imm       = imm_b;
            end
            OP_JAL: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.is_jal    = 1'b1;
                ctrl_o.wd_sel    = WD_PC4;
                ctrl_o.imm       = imm_j;
            end
            OP_JALR: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.is_jalr   = 1'b1;
                ctrl_o.wd_sel    = WD_PC4;
                ctrl_o.imm       = imm_i;
            end
            OP_LUI: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = ALU_PASSB;
                ctrl_o.imm         = imm_u;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: hw/rv_alu.sv
module rv_alu import rv_pkg::*; (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  alu_op_e     op_i,
    output logic [31:0] result_o,
    output logic        zero_o,
    output logic        lt_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];
    // signed compare, used by slt and by blt/bge
    assign lt_o = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD:   result_o = a_i + b_i;
            ALU_SUB:   result_o = a_i - b_i;
            ALU_AND:   result_o = a_i & b_i;
            ALU_OR:    result_o = a_i | b_i;
            ALU_XOR:   result_o = a_i ^ b_i;
            ALU_SLT:   result_o = {31'b0, lt_o};
            ALU_SLL:   result_o = a_i << shamt;
            ALU_SRL:   result_o = a_i >> shamt;
            ALU_SRA:   result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_PASSB: result_o = b_i;
            default:   result_o = a_i + b_i;
        endcase
    end

    assign zero_o = (result_o == 32'h0);

endmodule

// File: hw/rv_regfile.sv
module rv_regfile (
    input  logic        CPU_clk,
    input  logic        rstn,
    input  logic        we_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [31:0] regs [32];

    // x0 is never written
    always_ff @(posedge CPU_clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = (rs1_i == 5'd0) ? 32'h0 : regs[rs1_i];
    assign rd2_o = (rs2_i == 5'd0) ? 32'h0 : regs[rs2_i];

endmodule

// File: hw/rv_dmem.sv
module rv_dmem import rv_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        CPU_clk,
    input  logic        rstn,
    input  logic        we_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  mem_type_e   type_i,
    output logic [31:0] rdata_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   mem [DMEM_WORDS];
    logic [AW-1:0] idx;
    logic [31:0]   word;
    logic [7:0]    byte_lane;
    logic [15:0]   half_lane;
    logic          misaligned;

    // upper address bits drop out, so accesses wrap
    assign idx       = addr_i[AW+1:2];
    assign word      = mem[idx];
    assign byte_lane = word[{addr_i[1:0], 3'b000} +: 8];
    assign half_lane = word[{addr_i[1], 4'b0000} +: 16];

    always_ff @(posedge CPU_clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < DMEM_WORDS; k++) begin
                mem[k] <= '0;
            end
        end else if (we_i) begin
            case (type_i)
                MEM_B, MEM_BU: mem[idx][{addr_i[1:0], 3'b000} +: 8] <= wdata_i[7:0];
                MEM_H, MEM_HU: mem[idx][{addr_i[1], 4'b0000} +: 16] <= wdata_i[15:0];
                default:       mem[idx] <= wdata_i;
            endcase
        end
    end

    always_comb begin
        case (type_i)
            MEM_B:   rdata_o = {{24{byte_lane[7]}}, byte_lane};
            MEM_BU:  rdata_o = {24'h0, byte_lane};
            MEM_H:   rdata_o = {{16{half_lane[15]}}, half_lane};
            MEM_HU:  rdata_o = {16'h0, half_lane};
            default: rdata_o = word;
        endcase
    end

    // type reads as byte unless a load or store executes
    assign misaligned = ((type_i == MEM_H || type_i == MEM_HU) && addr_i[0]) ||
                        ((type_i == MEM_W) && (addr_i[1:0] != 2'b00));

    a_aligned: assert property (@(posedge CPU_clk) disable iff (!rstn) !misaligned)
        else $error("misaligned data access at %h", addr_i);

endmodule

// File: hw/rv_fetch.sv
module rv_fetch import rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        CPU_clk,
    input  logic        rstn,
    input  logic        fetch_en_i,
    output logic        imem_req_o,
    output logic [31:0] imem_addr_o,
    input  logic        imem_ack_i,
    input  logic [31:0] imem_rdata_i,
    output rv_instr_u   instr_o,
    output logic [31:0] pc_o,
    output logic        exec_o,
    input  ctrl_s       ctrl_i,
    input  logic        alu_zero_i,
    input  logic        alu_lt_i,
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] bp_addr_i,
    output logic        bp_hit_o,
    output retire_s     retire_o,
    input  logic [31:0] wdata_i
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_ACK_LOW, S_EXEC} state_e;

    state_e      state_q;
    logic [31:0] pc_q;
    logic [31:0] next_pc;
    rv_instr_u   instr_q;
    logic        taken;
    logic        rd_we;

    assign imem_req_o  = (state_q == S_REQ);
    assign imem_addr_o = pc_q;
    assign pc_o        = pc_q;
    assign exec_o      = (state_q == S_EXEC);
    // outside execute the all-zero word decodes to no writes
    assign instr_o     = exec_o ? instr_q : '0;
    assign bp_hit_o    = (state_q == S_IDLE) && (pc_q == bp_addr_i);

    always_comb begin
        case (instr_q.b.funct3)
            F3_BEQ:  taken = alu_zero_i;
            F3_BNE:  taken = !alu_zero_i;
            F3_BLT:  taken = alu_lt_i;
            F3_BGE:  taken = !alu_lt_i;
            default: taken = 1'b0;
        endcase
        if (ctrl_i.is_jalr) begin
            next_pc = (rs1_data_i + ctrl_i.imm) & ~32'h1;
        end else if (ctrl_i.is_jal || (ctrl_i.is_branch && taken)) begin
            next_pc = pc_q + ctrl_i.imm;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    assign rd_we = ctrl_i.reg_write && (instr_q.r.rd != 5'd0);

    always_ff @(posedge CPU_clk or negedge rstn) begin
        if (!rstn) begin
            state_q  <= S_IDLE;
            pc_q     <= RESET_PC;
            retire_o <= '0;
        end else begin
            retire_o.valid <= exec_o;
            case (state_q)
                S_IDLE:    if (fetch_en_i) state_q <= S_REQ;
                S_REQ:     if (imem_ack_i) state_q <= S_ACK_LOW;
                S_ACK_LOW: if (!imem_ack_i) state_q <= S_EXEC;
                default: begin
                    state_q        <= S_IDLE;
                    pc_q           <= next_pc;
                    retire_o.pc    <= pc_q;
                    retire_o.instr <= instr_q;
                    retire_o.rd    <= rd_we ? instr_q.r.rd : 5'd0;
                    retire_o.rd_we <= rd_we;
                    retire_o.wdata <= rd_we ? wdata_i : 32'h0;
                end
            endcase
        end
    end

    always_ff @(posedge CPU_clk) begin
        if (state_q == S_REQ && imem_ack_i) begin
            instr_q <= imem_rdata_i;
        end
    end

    // responder may only raise ack against a pending request
    a_ack_needs_req: assert property (@(posedge CPU_clk) disable iff (!rstn)
        $rose(imem_ack_i) |-> imem_req_o)
        else $error("fetch ack raised without a pending request");

endmodule

// File: hw/rv_dbg_regs.sv
module rv_dbg_regs import rv_pkg::*; (
    input  logic        CPU_clk,
    input  logic        rstn,
    input  logic        cfg_we_i,
    input  cfg_addr_e   cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    input  logic        exec_i,
    input  logic [31:0] pc_i,
    input  logic        bp_hit_i,
    output logic        fetch_en_o,
    output logic [31:0] bp_addr_o
);

    logic        run_q;
    logic        halted_q;
    logic        bp_en_q;
    logic [29:0] bp_word_q;
    logic [31:0] retired_q;
    logic        bp_skip_q;
    logic        bp_stop;

    // skip lets fetch resume at the breakpoint pc once
    assign bp_stop    = bp_en_q && bp_hit_i && !bp_skip_q;
    assign fetch_en_o = run_q && !halted_q && !bp_stop;
    assign bp_addr_o  = {bp_word_q, 2'b00};

    always_ff @(posedge CPU_clk or negedge rstn) begin
        if (!rstn) begin
            run_q     <= 1'b0;
            halted_q  <= 1'b0;
            bp_en_q   <= 1'b0;
            bp_word_q <= '0;
            retired_q <= '0;
            bp_skip_q <= 1'b0;
        end else begin
            if (exec_i) begin
                retired_q <= retired_q + 32'd1;
                bp_skip_q <= 1'b0;
            end
            if (run_q && bp_stop) halted_q <= 1'b1;
            // a write that clears halted wins over a new hit
            if (cfg_we_i && cfg_addr_i == CFG_CTRL) begin
                run_q <= cfg_wdata_i[0];
                if (cfg_wdata_i[1]) begin
                    halted_q  <= 1'b0;
                    bp_skip_q <= 1'b1;
                end
            end
            if (cfg_we_i && cfg_addr_i == CFG_BREAK) begin
                bp_en_q   <= cfg_wdata_i[0];
                bp_word_q <= cfg_wdata_i[31:2];
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            CFG_CTRL:    cfg_rdata_o = {30'h0, halted_q, run_q};
            CFG_BREAK:   cfg_rdata_o = {bp_word_q, 1'b0, bp_en_q};
            CFG_RETIRED: cfg_rdata_o = retired_q;
            default:     cfg_rdata_o = pc_i;
        endcase
    end

endmodule

// File: hw/rv_core_top.sv
module rv_core_top import rv_pkg::*; #(
    parameter int          DMEM_WORDS = 64,
    parameter logic [31:0] RESET_PC   = 32'h0
) (
    input  logic        CPU_clk,
    input  logic        rstn,
    output logic        imem_req_o,
    output logic [31:0] imem_addr_o,
    input  logic        imem_ack_i,
    input  logic [31:0] imem_rdata_i,
    input  logic        cfg_we_i,
    input  cfg_addr_e   cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    output retire_s     retire_o
);

    logic        fetch_en;
    logic        bp_hit;
    logic        exec;
    logic [31:0] bp_addr;
    logic [31:0] pc;
    rv_instr_u   instr;
    ctrl_s       ctrl;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic        alu_zero;
    logic        alu_lt;
    logic [31:0] dmem_rdata;
    logic [31:0] wd;

    // operand and writeback selection
    assign alu_b     = ctrl.alu_src_imm ? ctrl.imm : rd2;
    assign wd        = (ctrl.wd_sel == WD_MEM) ? dmem_rdata :
                       (ctrl.wd_sel == WD_PC4) ? pc + 32'd4 : alu_res;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .CPU_clk(CPU_clk), .rstn(rstn), .fetch_en_i(fetch_en),
        .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
        .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
        .instr_o(instr), .pc_o(pc), .exec_o(exec),
        .ctrl_i(ctrl), .alu_zero_i(alu_zero), .alu_lt_i(alu_lt), .rs1_data_i(rd1),
        .bp_addr_i(bp_addr), .bp_hit_o(bp_hit),
        .retire_o(retire_o), .wdata_i(wd)
    );

    rv_decode u_decode (.instr_i(instr), .ctrl_o(ctrl));

    rv_alu u_alu (
        .a_i(rd1), .b_i(alu_b), .op_i(ctrl.alu_op),
        .result_o(alu_res), .zero_o(alu_zero), .lt_o(alu_lt)
    );

    rv_regfile u_regfile (
        .CPU_clk(CPU_clk), .rstn(rstn), .we_i(ctrl.reg_write),
        .rs1_i(instr.r.rs1), .rs2_i(instr.r.rs2), .rd_i(instr.r.rd),
        .wd_i(wd), .rd1_o(rd1), .rd2_o(rd2)
    );

    // decode leaves the type at byte unless a load or store executes
    rv_dmem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
        .CPU_clk(CPU_clk), .rstn(rstn), .we_i(ctrl.mem_write), .addr_i(alu_res),
        .wdata_i(rd2), .type_i(ctrl.mem_type), .rdata_o(dmem_rdata)
    );

    rv_dbg_regs u_dbg (
        .CPU_clk(CPU_clk), .rstn(rstn),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o),
        .exec_i(exec), .pc_i(pc), .bp_hit_i(bp_hit),
        .fetch_en_o(fetch_en), .bp_addr_o(bp_addr)
    );

endmodule

// File: testbench/tb_rv_model.sv
module tb_rv_model;
    timeunit 1ns;
    timeprecision 1ps;

    integer      seed = 32'hf095;
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] pc;
    int unsigned retired;

    // prediction for the instruction executed last
    logic [31:0] exp_pc;
    logic [4:0]  exp_rd;
    logic        exp_we;
    logic [31:0] exp_wdata;

    task automatic reset_state(input logic [31:0] start_pc);
        for (int k = 0; k < 32; k++) begin
            regs[k] = 32'h0;
        end
        for (int k = 0; k < 64; k++) begin
            mem[k] = 32'h0;
        end
        pc = start_pc;
        retired = 0;
    endtask

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic int rand_delay();
        logic [31:0] r;
        r = rnd();
        rand_delay = {30'b0, r[1:0]};
    endfunction

    function automatic logic [31:0] gen_alu();
        logic [31:0] r;
        logic [31:0] v;
        int          sel;
        r = rnd();
        v = rnd();
        sel = rnd() % 15;
        case (sel)
            0:  gen_alu = {7'h00, r[14:10], r[9:5], 3'b000, r[4:0], 7'b0110011};
            1:  gen_alu = {7'h20, r[14:10], r[9:5], 3'b000, r[4:0], 7'b0110011};
            2:  gen_alu = {7'h00, r[14:10], r[9:5], 3'b111, r[4:0], 7'b0110011};
            3:  gen_alu = {7'h00, r[14:10], r[9:5], 3'b110, r[4:0], 7'b0110011};
            4:  gen_alu = {7'h00, r[14:10], r[9:5], 3'b100, r[4:0], 7'b0110011};
            5:  gen_alu = {7'h00, r[14:10], r[9:5], 3'b010, r[4:0], 7'b0110011};
            6:  gen_alu = {v[11:0], r[9:5], 3'b000, r[4:0], 7'b0010011};
            7:  gen_alu = {v[11:0], r[9:5], 3'b111, r[4:0], 7'b0010011};
            8:  gen_alu = {v[11:0], r[9:5], 3'b110, r[4:0], 7'b0010011};
            9:  gen_alu = {v[11:0], r[9:5], 3'b100, r[4:0], 7'b0010011};
            10: gen_alu = {v[11:0], r[9:5], 3'b010, r[4:0], 7'b0010011};
            11: gen_alu = {7'h00, v[4:0], r[9:5], 3'b001, r[4:0], 7'b0010011};
            12: gen_alu = {7'h00, v[4:0], r[9:5], 3'b101, r[4:0], 7'b0010011};
            13: gen_alu = {7'h20, v[4:0], r[9:5], 3'b101, r[4:0], 7'b0010011};
            default: gen_alu = {v[31:12], r[4:0], 7'b0110111};
        endcase
    endfunction

    // base is x0, the offset picks a lane that suits the width
    function automatic logic [31:0] gen_store(input logic [5:0] widx);
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0]  f3;
        int          sel;
        r = rnd();
        sel = rnd() % 3;
        case (sel)
            0:       begin f3 = 3'b000; imm = {4'h0, widx, r[1:0]}; end
            1:       begin f3 = 3'b001; imm = {4'h0, widx, r[1], 1'b0}; end
            default: begin f3 = 3'b010; imm = {4'h0, widx, 2'b00}; end
        endcase
        gen_store = {imm[11:5], r[8:4], 5'd0, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] gen_load(input logic [5:0] widx);
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0]  f3;
        int          sel;
        r = rnd();
        sel = rnd() % 5;
        case (sel)
            0:       begin f3 = 3'b000; imm = {4'h0, widx, r[1:0]}; end
            1:       begin f3 = 3'b100; imm = {4'h0, widx, r[1:0]}; end
            2:       begin f3 = 3'b001; imm = {4'h0, widx, r[1], 1'b0}; end
            3:       begin f3 = 3'b101; imm = {4'h0, widx, r[1], 1'b0}; end
            default: begin f3 = 3'b010; imm = {4'h0, widx, 2'b00}; end
        endcase
        gen_load = {imm, 5'd0, f3, r[8:4], 7'b0000011};
    endfunction

    // targets stay inside the first 256 bytes
    function automatic logic [31:0] gen_ctrl();
        logic [31:0] r;
        logic [31:0] target;
        logic [31:0] off;
        logic [4:0]  rs2;
        int          sel;
        r = rnd();
        target = {24'h0, r[7:2], 2'b00};
        off = target - pc;
        rs2 = r[31] ? r[12:8] : r[17:13];
        sel = rnd() % 7;
        case (sel)
            0, 1, 2, 3: gen_ctrl = {off[12], off[10:5], rs2, r[12:8],
                                    r[19] ? 3'b100 : 3'b000, off[4:1], off[11], 7'b1100011};
            4:       gen_ctrl = {off[12], off[10:5], rs2, r[12:8],
                                 r[19] ? 3'b101 : 3'b001, off[4:1], off[11], 7'b1100011};
            5:       gen_ctrl = {off[20], off[10:1], off[11], off[19:12], r[24:20], 7'b1101111};
            default: gen_ctrl = {4'h0, target[7:1], r[25], 5'd0, 3'b000, r[24:20], 7'b1100111};
        endcase
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic reg_form);
        case (f3)
            3'b000:  alu = (alt && reg_form) ? a - b : a + b;
            3'b001:  alu = a << b[4:0];
            3'b010:  alu = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
            3'b100:  alu = a ^ b;
            3'b101:  alu = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  alu = a | b;
            default: alu = a & b;
        endcase
    endfunction

    function automatic logic [31:0] load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] sh;
        sh = mem[addr[7:2]] >> {addr[1:0], 3'b000};
        case (f3)
            3'b000:  load = {{24{sh[7]}}, sh[7:0]};
            3'b100:  load = {24'h0, sh[7:0]};
            3'b001:  load = {{16{sh[15]}}, sh[15:0]};
            3'b101:  load = {16'h0, sh[15:0]};
            default: load = sh;
        endcase
    endfunction

    task automatic store(input logic [2:0] f3, input logic [31:0] addr, input logic [31:0] d);
        logic [31:0] mask;
        case (f3)
            3'b000:  mask = 32'h0000_00ff << {addr[1:0], 3'b000};
            3'b001:  mask = 32'h0000_ffff << {addr[1:0], 3'b000};
            default: mask = 32'hffff_ffff;
        endcase
        mem[addr[7:2]] = (mem[addr[7:2]] & ~mask) | ((d << {addr[1:0], 3'b000}) & mask);
    endtask

    task automatic execute(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        take;
        logic        we;
        rd = ins[11:7];
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        res = 32'h0;
        we = 1'b0;
        nxt = pc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin we = 1'b1; res = alu(ins[14:12], ins[30], a, b, 1'b1); end
            7'b0010011: begin we = 1'b1; res = alu(ins[14:12], ins[30], a, imm_i, 1'b0); end
            7'b0110111: begin we = 1'b1; res = {ins[31:12], 12'h000}; end
            7'b0000011: begin we = 1'b1; res = load(ins[14:12], a + imm_i); end
            7'b0100011: store(ins[14:12], a + imm_s, b);
            7'b1100011: begin
                case (ins[14:12])
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = $signed(a) < $signed(b);
                    default: take = $signed(a) >= $signed(b);
                endcase
                if (take) nxt = pc + imm_b;
            end
            7'b1101111: begin we = 1'b1; res = pc + 32'd4; nxt = pc + imm_j; end
            default: begin we = 1'b1; res = pc + 32'd4; nxt = (a + imm_i) & ~32'h1; end
        endcase
        exp_we = we && (rd != 5'd0);
        exp_rd = exp_we ? rd : 5'd0;
        exp_wdata = exp_we ? res : 32'h0;
        if (exp_we) regs[rd] = res;
        exp_pc = pc;
        pc = nxt;
        retired = retired + 1;
    endtask

endmodule

// File: testbench/tb_top.sv
module tb_top import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic        CPU_clk = 1'b0;
    logic        rstn;
    logic        imem_req_o;
    logic [31:0] imem_addr_o;
    logic        imem_ack_i;
    logic [31:0] imem_rdata_i;
    logic        cfg_we_i;
    cfg_addr_e   cfg_addr_i;
    logic [31:0] cfg_wdata_i;
    logic [31:0] cfg_rdata_o;
    retire_s     retire_o;

    int          total_errors = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          aborted = 1'b0;

    rv_core_top #(.DMEM_WORDS(64), .RESET_PC(32'h0)) dut (
        .CPU_clk(CPU_clk), .rstn(rstn),
        .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
        .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o),
        .retire_o(retire_o)
    );

    tb_rv_model model ();

    always #5 CPU_clk = ~CPU_clk;

    task automatic tick();
        @(posedge CPU_clk);
        #1;
    endtask

    task automatic check32(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic cfg_write(input cfg_addr_e addr, input logic [31:0] data);
        cfg_we_i = 1'b1;
        cfg_addr_i = addr;
        cfg_wdata_i = data;
        tick();
        cfg_we_i = 1'b0;
    endtask

    // read port is combinational
    task automatic cfg_read(input cfg_addr_e addr, output logic [31:0] data);
        cfg_addr_i = addr;
        #2;
        data = cfg_rdata_o;
    endtask

    task automatic wait_req(input int limit);
        int n;
        n = 0;
        while (!imem_req_o && n < limit) begin
            tick();
            n++;
        end
        if (!imem_req_o) begin
            $display("timeout: no fetch request within %0d cycles", limit);
            test_errors++;
            aborted = 1'b1;
        end
    endtask

    // one full fetch handshake, then the retire check
    task automatic step(input logic [31:0] ins);
        int n;
        int dly;
        if (aborted) return;
        wait_req(50);
        if (aborted) return;
        check32("imem_addr_o", model.pc, imem_addr_o);
        dly = model.rand_delay();
        repeat (dly) tick();
        imem_ack_i = 1'b1;
        imem_rdata_i = ins;
        n = 0;
        tick();
        while (imem_req_o && n < 20) begin
            tick();
            n++;
        end
        if (imem_req_o) begin
            $display("timeout: fetch request held high after ack");
            test_errors++;
            aborted = 1'b1;
            return;
        end
        imem_ack_i = 1'b0;
        imem_rdata_i = 32'h0;
        model.execute(ins);
        n = 0;
        while (!retire_o.valid && n < 20) begin
            tick();
            n++;
        end
        if (!retire_o.valid) begin
            $display("timeout: instruction %h never retired", ins);
            test_errors++;
            aborted = 1'b1;
            return;
        end
        check32("retire_o.pc", model.exp_pc, retire_o.pc);
        check32("retire_o.instr", ins, retire_o.instr);
        check32("retire_o.rd", {27'h0, model.exp_rd}, {27'h0, retire_o.rd});
        check32("retire_o.rd_we", {31'h0, model.exp_we}, {31'h0, retire_o.rd_we});
        check32("retire_o.wdata", model.exp_wdata, retire_o.wdata);
        if (retire_o.rd_we && retire_o.rd == 5'd0) begin
            $display("write enable set for x0 at pc %h", retire_o.pc);
            test_errors++;
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] bp;
        logic [31:0] r;
        bit          seen;
        rstn = 1'b0;
        imem_ack_i = 1'b0;
        imem_rdata_i = 32'h0;
        cfg_we_i = 1'b0;
        cfg_addr_i = CFG_CTRL;
        cfg_wdata_i = 32'h0;
        model.reset_state(32'h0);
        repeat (16) tick();
        rstn = 1'b1;

        seen = 1'b0;
        repeat (50) begin
            tick();
            if (imem_req_o) seen = 1'b1;
        end
        if (seen) begin
            $display("fetch request raised while the run bit was clear");
            test_errors++;
        end
        cfg_write(CFG_CTRL, 32'h1);
        wait_req(20);
        end_test("run control");

        for (int k = 0; k < 300; k++) begin
            step(model.gen_alu());
        end
        end_test("alu and immediate");

        for (int k = 0; k < 40; k++) begin
            r = model.rnd();
            step(model.gen_store(r[5:0]));
            step(model.gen_load(r[5:0]));
        end
        end_test("store and load");

        for (int k = 0; k < 60; k++) begin
            step(model.gen_ctrl());
        end
        end_test("branch and jump");

        // halt two instructions ahead, then resume there
        bp = model.pc + 32'd8;
        cfg_write(CFG_BREAK, bp | 32'h1);
        step(model.gen_alu());
        step(model.gen_alu());
        seen = 1'b0;
        repeat (30) begin
            tick();
            if (imem_req_o) seen = 1'b1;
        end
        if (seen) begin
            $display("fetch request made at the breakpoint address");
            test_errors++;
        end
        cfg_read(CFG_CTRL, rd);
        check32("cfg_rdata_o(CFG_CTRL)", 32'h3, rd);
        cfg_read(CFG_PC, rd);
        check32("cfg_rdata_o(CFG_PC)", bp, rd);
        tick();
        cfg_write(CFG_CTRL, 32'h3);
        step(model.gen_alu());
        cfg_write(CFG_BREAK, 32'h0);
        end_test("breakpoint");

        cfg_read(CFG_RETIRED, rd);
        check32("cfg_rdata_o(CFG_RETIRED)", model.retired, rd);
        end_test("retired count");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_dmem.sv
hw/rv_fetch.sv
hw/rv_dbg_regs.sv
hw/rv_core_top.sv
testbench/tb_rv_model.sv
testbench/tb_top.sv

// File: Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the simulation prints the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
